/* include/spi_macros.svh */
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// widest character the transceiver can shift
`define SPI_CHAR_NBITS 32

// length code, character is code + 1 bits
`define SPI_LEN_WIDTH 5

// sck half period is divider + 1 system clocks
`define SPI_DIV_WIDTH 8

// transmit queue entries, also the host's starting tx credits
`define SPI_TX_DEPTH 4

// characters the host can take after reset
`define SPI_RX_CREDITS 2

// largest value any credit counter has to hold
`define SPI_CREDIT_MAX \
    ((`SPI_TX_DEPTH > `SPI_RX_CREDITS) ? `SPI_TX_DEPTH : `SPI_RX_CREDITS)

`endif

/* hw/spi_pkg.sv */
`include "spi_macros.svh"

package spi_pkg;

    // one character, data right aligned
    typedef logic [`SPI_CHAR_NBITS-1:0] spi_char_t;

    // character length code
    typedef logic [`SPI_LEN_WIDTH-1:0] spi_len_t;

    // sck divider setting
    typedef logic [`SPI_DIV_WIDTH-1:0] spi_div_t;

    // bit index, one bit wider than the char index
    typedef logic [$clog2(`SPI_CHAR_NBITS):0] spi_bitcnt_t;

    // tx and rx credit counters
    typedef logic [$clog2(`SPI_CREDIT_MAX + 1)-1:0] spi_credit_t;

    typedef enum logic [2:0] {
        IDLE,     // ss_n high, waiting for data and a credit
        SETUP,    // head char taken, first bit set up
        SHIFT,    // bits moving on sck strobes
        HOLD,     // ss_n held low for one half period
        DELIVER   // ss_n back high, char to host
    } trx_state_t;

endpackage

/* hw/spi_clk_gen.sv */
`timescale 1ns/100ps

module spi_clk_gen (
    input  logic              S_CHAR_GO,
    input  logic              S_RESETN,
    input  logic              cpol,
    input  spi_pkg::spi_div_t divider,
    input  logic              sck_run,
    output logic              sck,
    output logic              sck_lead,
    output logic              sck_trail
);

    spi_pkg::spi_div_t half_cnt;   // counts down to the next edge
    logic              sck_tgl;    // 0 = at rest level, flips per edge
    logic              edge_stb;

    // zero count while stopped, so the first edge comes right away
    assign edge_stb = sck_run && (half_cnt == '0);

    // even strobes lead, odd strobes trail
    assign sck_lead  = edge_stb && !sck_tgl;
    assign sck_trail = edge_stb && sck_tgl;

    // rest level whenever the transceiver is not shifting
    assign sck = cpol ^ (sck_run & sck_tgl);

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            half_cnt <= '0;
            sck_tgl  <= 1'b0;
        end else if (!sck_run) begin
            half_cnt <= '0;   // cleared between characters
            sck_tgl  <= 1'b0;
        end else if (edge_stb) begin
            half_cnt <= divider;   // reload for next half period
            sck_tgl  <= ~sck_tgl;
        end else begin
            half_cnt <= half_cnt - 1'b1;
        end
    end

endmodule

/* hw/spi_tx_queue.sv */
`timescale 1ns/100ps
`include "spi_macros.svh"

module spi_tx_queue #(
    parameter int DEPTH = `SPI_TX_DEPTH
) (
    input  logic               S_CHAR_GO,
    input  logic               S_RESETN,
    input  logic               tx_valid,
    input  spi_pkg::spi_char_t tx_char,
    input  logic               q_pop,
    output logic               tx_credit,
    output logic               q_empty,
    output spi_pkg::spi_char_t q_char
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    spi_pkg::spi_char_t mem [DEPTH];   // character storage

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   occupancy;   // entries held, 0 to DEPTH
    logic             push;
    logic             pop;

    // push into a full queue is dropped
    assign push = tx_valid && (occupancy != FULL_COUNT);
    assign pop  = q_pop && (occupancy != '0);

    assign q_empty = (occupancy == '0);
    assign q_char  = mem[rd_ptr];   // head entry

    always_ff @(posedge S_CHAR_GO) begin
        if (push) begin
            mem[wr_ptr] <= tx_char;
        end
    end

    // pointers wrap on their own, DEPTH is a power of two
    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            occupancy <= '0;
        end else begin
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;   // both or neither
            endcase
        end
    end

    // one credit back to the host per entry taken
    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            tx_credit <= 1'b0;
        end else begin
            tx_credit <= pop;
        end
    end

endmodule

/* hw/spi_trx_char.sv */
`timescale 1ns/100ps
`include "spi_macros.svh"

module spi_trx_char (
    input  logic               S_CHAR_GO,
    input  logic               S_RESETN,
    input  logic               enable,
    input  logic               cpol,
    input  logic               cpha,
    input  logic               rev,
    input  logic               loop,
    input  spi_pkg::spi_len_t  char_len,
    input  logic               q_empty,
    input  spi_pkg::spi_char_t q_char,
    input  logic               sck_lead,
    input  logic               sck_trail,
    input  logic               miso,
    input  logic               rx_credit,
    output logic               q_pop,
    output logic               sck_run,
    output logic               ss_n,
    output logic               mosi,
    output logic               rx_valid,
    output spi_pkg::spi_char_t rx_char
);

    localparam int IDX_W = $clog2(`SPI_CHAR_NBITS);

    spi_pkg::trx_state_t  state;
    spi_pkg::spi_char_t   tx_word;     // char being sent
    spi_pkg::spi_char_t   rx_word;     // char being received
    spi_pkg::spi_bitcnt_t bit_idx;     // current bit position
    spi_pkg::spi_bitcnt_t first_idx;
    spi_pkg::spi_bitcnt_t last_idx;
    spi_pkg::spi_bitcnt_t next_idx;
    spi_pkg::spi_len_t    len_q;
    spi_pkg::spi_credit_t rx_cred;     // chars the host can still take
    logic                 cpha_q;      // cpha of this char
    logic                 rev_q;
    logic                 loop_q;
    logic                 sample_lead; // sample on leading edge
    logic                 sample_stb;
    logic                 shift_stb;
    logic                 last_bit;
    logic                 din;
    logic                 start;

    // the state alone decides the framing outputs
    assign q_pop    = (state == spi_pkg::SETUP);
    assign sck_run  = (state == spi_pkg::SHIFT) || (state == spi_pkg::HOLD);
    assign ss_n     = !((state == spi_pkg::SETUP) || sck_run);
    assign rx_valid = (state == spi_pkg::DELIVER);
    assign rx_char  = rx_word;

    assign start = enable && !q_empty && (rx_cred != '0);

    // cpha=0 samples first, cpha=1 shifts first
    assign sample_lead = !cpha_q;

    assign sample_stb = sample_lead ? sck_lead : sck_trail;
    assign shift_stb  = sample_lead ? sck_trail : sck_lead;

    // walk up from bit 0, or down from the top bit when reversed
    assign first_idx = rev_q ? spi_pkg::spi_bitcnt_t'(len_q) : '0;
    assign last_idx  = rev_q ? '0 : spi_pkg::spi_bitcnt_t'(len_q);
    assign next_idx  = rev_q ? bit_idx - 1'b1 : bit_idx + 1'b1;
    assign last_bit  = (bit_idx == last_idx);

    assign din = loop_q ? mosi : miso;   // loopback reads our own mosi

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state   <= spi_pkg::IDLE;
            bit_idx <= '0;
            mosi    <= 1'b1;
            cpha_q  <= 1'b0;
            rev_q   <= 1'b0;
            loop_q  <= 1'b0;
            len_q   <= '0;
        end else begin
            case (state)
                spi_pkg::IDLE: begin
                    if (start) begin
                        state  <= spi_pkg::SETUP;
                        cpha_q <= cpha;   // config frozen for this char
                        rev_q  <= rev;
                        loop_q <= loop;
                        len_q  <= char_len;
                    end
                end
                spi_pkg::SETUP: begin
                    bit_idx <= first_idx;
                    // cpha=0 needs the first bit out before the leading edge
                    if (sample_lead) begin
                        mosi <= q_char[first_idx[IDX_W-1:0]];
                    end
                    state <= spi_pkg::SHIFT;
                end
                spi_pkg::SHIFT: begin
                    if (shift_stb) begin
                        if (!sample_lead) begin
                            mosi <= tx_word[bit_idx[IDX_W-1:0]];   // cpha=1 current bit
                        end else if (!last_bit) begin
                            mosi <= tx_word[next_idx[IDX_W-1:0]];  // cpha=0 next bit
                        end
                    end
                    // every bit ends on a trailing edge
                    if (sck_trail) begin
                        if (last_bit) begin
                            state <= spi_pkg::HOLD;
                        end else begin
                            bit_idx <= next_idx;
                        end
                    end
                end
                spi_pkg::HOLD: begin
                    if (sck_lead) begin
                        state <= spi_pkg::DELIVER;   // half period after last edge
                    end
                end
                spi_pkg::DELIVER: begin
                    mosi  <= 1'b1;   // idle level
                    state <= spi_pkg::IDLE;
                end
                default: begin
                    state <= spi_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge S_CHAR_GO) begin
        if (state == spi_pkg::SETUP) begin
            tx_word <= q_char;
            rx_word <= '0;   // bits above the length stay zero
        end else if ((state == spi_pkg::SHIFT) && sample_stb) begin
            rx_word[bit_idx[IDX_W-1:0]] <= din;
        end
    end

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            rx_cred <= spi_pkg::spi_credit_t'(`SPI_RX_CREDITS);
        end else if (rx_credit && !rx_valid) begin
            rx_cred <= rx_cred + 1'b1;
        end else if (!rx_credit && rx_valid) begin
            rx_cred <= rx_cred - 1'b1;
        end
    end

endmodule

/* hw/spi_master_top.sv */
`timescale 1ns/100ps

module spi_master_top (
    input  logic               S_CHAR_GO,
    input  logic               S_RESETN,
    input  logic               enable,
    input  logic               cpol,
    input  logic               cpha,
    input  logic               rev,
    input  logic               loop,
    input  spi_pkg::spi_len_t  char_len,
    input  spi_pkg::spi_div_t  divider,
    input  logic               tx_valid,
    input  spi_pkg::spi_char_t tx_char,
    output logic               tx_credit,
    output logic               rx_valid,
    output spi_pkg::spi_char_t rx_char,
    input  logic               rx_credit,
    output logic               sck,
    output logic               ss_n,
    output logic               mosi,
    input  logic               miso
);

    logic               q_empty;
    logic               q_pop;
    spi_pkg::spi_char_t q_char;     // head of the tx queue
    logic               sck_run;
    logic               sck_lead;
    logic               sck_trail;

    spi_tx_queue u_tx_queue (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .tx_valid  (tx_valid),
        .tx_char   (tx_char),
        .q_pop     (q_pop),
        .tx_credit (tx_credit),
        .q_empty   (q_empty),
        .q_char    (q_char)
    );

    spi_trx_char u_trx (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .enable    (enable),
        .cpol      (cpol),
        .cpha      (cpha),
        .rev       (rev),
        .loop      (loop),
        .char_len  (char_len),
        .q_empty   (q_empty),
        .q_char    (q_char),
        .sck_lead  (sck_lead),
        .sck_trail (sck_trail),
        .miso      (miso),
        .rx_credit (rx_credit),
        .q_pop     (q_pop),
        .sck_run   (sck_run),
        .ss_n      (ss_n),
        .mosi      (mosi),
        .rx_valid  (rx_valid),
        .rx_char   (rx_char)
    );

    spi_clk_gen u_clk_gen (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .cpol      (cpol),
        .divider   (divider),
        .sck_run   (sck_run),
        .sck       (sck),
        .sck_lead  (sck_lead),
        .sck_trail (sck_trail)
    );

endmodule

/* test/spi_master_assert.sv */
`timescale 1ns/100ps
`include "spi_macros.svh"

module spi_master_assert (
    input logic                             S_CHAR_GO,
    input logic                             S_RESETN,
    input logic                             cpol,
    input logic                             sck,
    input logic                             ss_n,
    input logic                             rx_valid,
    input logic                             tx_credit,
    input logic                             tx_valid,
    input logic [$clog2(`SPI_TX_DEPTH):0]   occupancy
);

    // sck parked at its rest level outside a character
    sck_rest_a : assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        ss_n |-> (sck == cpol))
        else $error("sck left its rest level while ss_n is high");

    rx_valid_pulse_a : assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        rx_valid |=> !rx_valid)
        else $error("rx_valid held longer than one cycle");

    tx_credit_pulse_a : assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        tx_credit |=> !tx_credit)
        else $error("tx_credit held longer than one cycle");

    occupancy_a : assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        occupancy <= `SPI_TX_DEPTH)
        else $error("tx queue occupancy above its depth");

    // a push with no credit left
    push_full_a : assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        tx_valid |-> (occupancy != `SPI_TX_DEPTH))
        else $error("tx_valid while the tx queue is full");

endmodule

bind spi_master_top spi_master_assert u_assert (
    .S_CHAR_GO (S_CHAR_GO),
    .S_RESETN  (S_RESETN),
    .cpol      (cpol),
    .sck       (sck),
    .ss_n      (ss_n),
    .rx_valid  (rx_valid),
    .tx_credit (tx_credit),
    .tx_valid  (tx_valid),
    .occupancy (u_tx_queue.occupancy)
);

/* include/spi_tb_macros.svh */
`ifndef SPI_TB_MACROS_SVH
`define SPI_TB_MACROS_SVH

// system clock period in ns
`define TB_CLK_PERIOD 20

// characters pushed over the whole run
`define TB_NUM_CHARS 42

// longest character, 32 bits at the slowest divider
`define TB_WORST_CLKS (2 + 2 * `SPI_CHAR_NBITS * 256)

`endif

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps
`include "spi_macros.svh"
`include "spi_tb_macros.svh"

module tb_clock_gen (
    output logic S_CHAR_GO,
    output logic S_RESETN
);

    initial begin
        S_CHAR_GO = 1'b0;
        forever #(`TB_CLK_PERIOD / 2) S_CHAR_GO = ~S_CHAR_GO;
    end

    // reset held over the first 3 rising edges
    initial begin
        S_RESETN = 1'b0;
        repeat (3) @(posedge S_CHAR_GO);
        @(negedge S_CHAR_GO);
        S_RESETN = 1'b1;
    end

endmodule

/* test/tb_spi_master.sv */
`timescale 1ns/100ps
`include "spi_macros.svh"
`include "spi_tb_macros.svh"

module tb_spi_master;

    localparam longint WATCHDOG_NS =
        longint'(`TB_NUM_CHARS) * `TB_WORST_CLKS * 2 * `TB_CLK_PERIOD + 200000;
    localparam int DRAIN_LIMIT = 8 * `TB_WORST_CLKS;

    logic               S_CHAR_GO;
    logic               S_RESETN;
    logic               enable;
    logic               cpol;
    logic               cpha;
    logic               rev;
    logic               loop;
    spi_pkg::spi_len_t  char_len;
    spi_pkg::spi_div_t  divider;
    logic               tx_valid;
    spi_pkg::spi_char_t tx_char;
    logic               tx_credit;
    logic               rx_valid;
    spi_pkg::spi_char_t rx_char;
    logic               rx_credit;
    logic               sck;
    logic               ss_n;
    logic               mosi;
    logic               miso;

    integer             seed;
    int                 value_errs;
    int                 proto_errs;
    int                 push_count;
    int                 rx_count;
    int                 rx_returned;
    int                 tx_cred;       // host view of tx credits
    logic               hold_rx;       // host withholds rx credits
    spi_pkg::spi_char_t captured;      // mosi word seen by the slave
    spi_pkg::spi_char_t exp_tx_q[$];
    spi_pkg::spi_char_t exp_word_q[$];
    spi_pkg::spi_len_t  exp_len_q[$];
    logic               exp_loop_q[$];
    spi_pkg::spi_char_t slave_q[$];

    tb_clock_gen u_clk (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN)
    );

    spi_master_top u_dut (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .enable    (enable),
        .cpol      (cpol),
        .cpha      (cpha),
        .rev       (rev),
        .loop      (loop),
        .char_len  (char_len),
        .divider   (divider),
        .tx_valid  (tx_valid),
        .tx_char   (tx_char),
        .tx_credit (tx_credit),
        .rx_valid  (rx_valid),
        .rx_char   (rx_char),
        .rx_credit (rx_credit),
        .sck       (sck),
        .ss_n      (ss_n),
        .mosi      (mosi),
        .miso      (miso)
    );

    // low len+1 bits, each bit keeps its position whatever the order
    function automatic spi_pkg::spi_char_t spi_expect(input spi_pkg::spi_char_t word,
                                                      input spi_pkg::spi_len_t len);
        spi_pkg::spi_char_t mask;
        mask = '1;
        mask = mask >> ((`SPI_CHAR_NBITS - 1) - int'(len));
        return word & mask;
    endfunction

    task automatic check_char(input string name, input spi_pkg::spi_char_t exp,
                              input spi_pkg::spi_char_t act);
        if (exp !== act) begin
            value_errs++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_credit(input string name, input spi_pkg::spi_credit_t exp,
                                input spi_pkg::spi_credit_t act);
        if (exp !== act) begin
            value_errs++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic set_config(input logic pol, input logic pha, input logic order,
                              input logic lpbk, input spi_pkg::spi_len_t len,
                              input spi_pkg::spi_div_t div);
        @(negedge S_CHAR_GO);
        cpol     = pol;
        cpha     = pha;
        rev      = order;
        loop     = lpbk;
        char_len = len;
        divider  = div;
    endtask

    // called on a falling edge, returns on the next one
    task automatic push_char(input spi_pkg::spi_char_t data, input spi_pkg::spi_char_t word);
        while (tx_cred == 0) @(negedge S_CHAR_GO);
        tx_valid = 1'b1;
        tx_char  = data;
        exp_tx_q.push_back(data);
        exp_word_q.push_back(word);
        exp_len_q.push_back(char_len);
        exp_loop_q.push_back(loop);
        slave_q.push_back(word);
        push_count++;
        @(negedge S_CHAR_GO);
        tx_valid = 1'b0;
    endtask

    task automatic wait_rx(input int target);
        int n;
        n = 0;
        while ((rx_count < target || !ss_n) && n < DRAIN_LIMIT) begin
            @(negedge S_CHAR_GO);
            n++;
        end
        if (n >= DRAIN_LIMIT) begin
            proto_errs++;
            $display("timed out waiting for %0d received characters, got %0d", target,
                     rx_count);
        end
        repeat (2) @(negedge S_CHAR_GO);   // let the credit return settle
    endtask

    task automatic push_random(input int count);
        repeat (count) push_char($random(seed), $random(seed));
    endtask

    // host side tx credit counter
    always @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            tx_cred <= `SPI_TX_DEPTH;
        end else begin
            tx_cred <= tx_cred - int'(tx_valid) + int'(tx_credit);
        end
    end

    // hand rx credits back one per cycle unless held
    always @(negedge S_CHAR_GO) begin
        if (!hold_rx && rx_returned < rx_count) begin
            rx_credit = 1'b1;
            rx_returned++;
        end else begin
            rx_credit = 1'b0;
        end
    end

    // slave model, follows the sck edges inside each ss_n frame
    always begin : slave_model
        int                 idx;
        logic               lead;
        spi_pkg::spi_char_t word;
        @(negedge ss_n);
        word     = (slave_q.size() > 0) ? slave_q.pop_front() : '0;
        idx      = rev ? int'(char_len) : 0;
        captured = '0;
        if (!cpha) begin
            miso = word[idx];   // first bit before the leading edge
        end
        while (!ss_n) begin
            @(sck or posedge ss_n);
            if (!ss_n) begin
                lead = (sck != cpol);
                if (lead == !cpha) begin
                    if (idx >= 0 && idx < `SPI_CHAR_NBITS) captured[idx] = mosi;
                    if (cpha) idx = rev ? idx - 1 : idx + 1;
                end else begin
                    if (!cpha) idx = rev ? idx - 1 : idx + 1;
                    if (idx >= 0 && idx < `SPI_CHAR_NBITS) miso = word[idx];
                end
            end
        end
    end

    // compare each received character with the reference
    always @(posedge S_CHAR_GO) begin
        spi_pkg::spi_char_t tx_exp;
        spi_pkg::spi_char_t word_exp;
        spi_pkg::spi_len_t  len_exp;
        logic               loop_exp;
        if (S_RESETN && rx_valid) begin
            rx_count++;
            if (exp_tx_q.size() == 0) begin
                proto_errs++;
                $display("rx_valid with no character outstanding");
            end else begin
                tx_exp   = exp_tx_q.pop_front();
                word_exp = exp_word_q.pop_front();
                len_exp  = exp_len_q.pop_front();
                loop_exp = exp_loop_q.pop_front();
                check_char("rx_char", spi_expect(loop_exp ? tx_exp : word_exp, len_exp),
                           rx_char);
                check_char("mosi_word", spi_expect(tx_exp, len_exp), captured);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        int base;
        int len_tab[3];
        seed        = 17;
        value_errs  = 0;
        proto_errs  = 0;
        push_count  = 0;
        rx_count    = 0;
        rx_returned = 0;
        hold_rx     = 1'b0;
        enable      = 1'b0;
        cpol        = 1'b0;
        cpha        = 1'b0;
        rev         = 1'b0;
        loop        = 1'b0;
        char_len    = '0;
        divider     = '0;
        tx_valid    = 1'b0;
        tx_char     = '0;
        rx_credit   = 1'b0;
        miso        = 1'b0;
        captured    = '0;
        len_tab     = '{0, 15, 31};
        @(posedge S_RESETN);
        @(negedge S_CHAR_GO);
        enable = 1'b1;

        // four modes, 8 bits, msb first
        for (int m = 0; m < 4; m++) begin
            set_config(m[1], m[0], 1'b1, 1'b0, 5'd7, spi_pkg::spi_div_t'($random(seed) & 3));
            push_random(3);
            wait_rx(push_count);
        end

        // bit order against length
        for (int r = 0; r < 2; r++) begin
            for (int l = 0; l < 3; l++) begin
                set_config(1'b0, 1'b0, r[0], 1'b0, spi_pkg::spi_len_t'(len_tab[l]), 8'd1);
                push_random(2);
                wait_rx(push_count);
            end
        end

        // loopback ignores miso
        set_config(1'b1, 1'b1, 1'b0, 1'b1, 5'd11, 8'd0);
        push_random(4);
        wait_rx(push_count);

        // fill the queue while stalled, host ends with no credit
        set_config(1'b0, 1'b1, 1'b1, 1'b0, 5'd7, 8'd2);
        enable = 1'b0;
        push_random(`SPI_TX_DEPTH);
        check_credit("tx_credits", '0, spi_pkg::spi_credit_t'(tx_cred));
        enable = 1'b1;
        wait_rx(push_count);
        check_credit("tx_credits", `SPI_TX_DEPTH, spi_pkg::spi_credit_t'(tx_cred));

        // rx back-pressure
        hold_rx = 1'b1;
        base    = rx_count;
        push_random(4);
        wait_rx(base + `SPI_RX_CREDITS);
        repeat (300) begin
            @(negedge S_CHAR_GO);
            if (!ss_n) begin
                proto_errs++;
                $display("ss_n went low with no rx credit left");
            end
        end
        check_credit("rx_arrived", `SPI_RX_CREDITS, spi_pkg::spi_credit_t'(rx_count - base));
        hold_rx = 1'b0;
        wait_rx(push_count);

        // random dividers and modes, one char each
        for (int k = 0; k < 6; k++) begin
            set_config(1'($random(seed)), 1'($random(seed)), 1'($random(seed)), 1'b0, 5'd7,
                       spi_pkg::spi_div_t'($random(seed)));
            push_random(1);
            wait_rx(push_count);
        end

        if (rx_count != push_count) begin
            proto_errs++;
            $display("received %0d characters for %0d pushed", rx_count, push_count);
        end
        $display("value errors %0d, protocol errors %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
hw/spi_pkg.sv
hw/spi_clk_gen.sv
hw/spi_tx_queue.sv
hw/spi_trx_char.sv
hw/spi_master_top.sv
test/spi_master_assert.sv
test/tb_clock_gen.sv
test/tb_spi_master.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_spi_master
FILELIST  := build.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
